//--- rtl/sdio_pkg.sv
package sdio_pkg;

    localparam int CMD_LEN   = 6;
    localparam int ARG_LEN   = 32;
    localparam int CRC_LEN   = 7;
    localparam int FRAME_LEN = 48;

    // Start, transmission, index and argument are covered by the CRC
    localparam int BODY_LEN = 2 + CMD_LEN + ARG_LEN;
    localparam int CNT_W    = $clog2(FRAME_LEN);

    localparam logic [CMD_LEN-1:0] CMD_GO_IDLE      = 6'd0;
    localparam logic [CMD_LEN-1:0] CMD_IO_RW_DIRECT = 6'd52;

    // CMD52 argument layout
    localparam int RW_FLAG_BIT = 31;
    localparam int REG_ADDR_HI = 25;
    localparam int REG_ADDR_LO = 9;
    localparam int WR_DATA_HI  = 7;
    localparam int WR_DATA_LO  = 0;

    typedef struct packed {
        logic [CMD_LEN-1:0] index;
        logic [ARG_LEN-1:0] arg;
    } cmd_frame_t;

    typedef struct packed {
        logic [CMD_LEN-1:0] index;
        logic [ARG_LEN-1:0] arg;  // Data byte in the low bits
    } resp_frame_t;

endpackage

//--- rtl/sdio_crc7.sv
`timescale 1ns/10ps

module sdio_crc7 import sdio_pkg::*; (
    input  logic               clk_sdio,
    input  logic               arst_n,
    input  logic               clear,
    input  logic               enable,
    input  logic               data_bit,
    output logic [CRC_LEN-1:0] crc
);

    logic fb;

    assign fb = data_bit ^ crc[CRC_LEN-1];

    // x^7 + x^3 + 1
    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

endmodule

//--- rtl/sdio_cmd_rx.sv
`timescale 1ns/10ps

module sdio_cmd_rx import sdio_pkg::*; (
    input  logic       clk_sdio,
    input  logic       arst_n,
    input  logic       cmd_in,
    output logic       cmd_valid,
    output cmd_frame_t cmd,
    output logic       crc_error
);

    localparam int CMD_W = $bits(cmd_frame_t);

    localparam logic [CNT_W-1:0] TX_BIT   = CNT_W'(1);
    localparam logic [CNT_W-1:0] BODY_END = CNT_W'(BODY_LEN - 1);
    localparam logic [CNT_W-1:0] CRC_END  = CNT_W'(FRAME_LEN - 2);
    localparam logic [CNT_W-1:0] END_BIT  = CNT_W'(FRAME_LEN - 1);

    logic               cmd_prev;
    logic               busy;
    logic [CNT_W-1:0]   bit_cnt;  // Position of the bit sampled this edge
    cmd_frame_t         cmd_sr;
    logic [CRC_LEN-1:0] crc_rx;
    logic [CRC_LEN-1:0] crc_calc;
    logic               crc_en;

    // Start bit needs no feed, a zero into a cleared CRC leaves it zero
    assign crc_en = busy && (bit_cnt <= BODY_END);

    sdio_crc7 u_crc (
        .clk_sdio (clk_sdio),
        .arst_n   (arst_n),
        .clear    (!busy),
        .enable   (crc_en),
        .data_bit (cmd_in),
        .crc      (crc_calc)
    );

    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            cmd_prev  <= 1'b0;
            busy      <= 1'b0;
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
            crc_error <= 1'b0;
        end else begin
            cmd_prev  <= cmd_in;
            cmd_valid <= 1'b0;
            crc_error <= 1'b0;
            if (!busy) begin
                if (cmd_prev && !cmd_in) begin  // Start bit
                    busy    <= 1'b1;
                    bit_cnt <= TX_BIT;
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == TX_BIT && !cmd_in) begin
                    busy <= 1'b0;  // Card-to-host frame, not ours
                end else if (bit_cnt == END_BIT) begin
                    busy <= 1'b0;
                    if (cmd_in && crc_rx == crc_calc) begin
                        cmd_valid <= 1'b1;
                    end else begin
                        crc_error <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_sdio) begin
        if (busy && bit_cnt > TX_BIT && bit_cnt <= BODY_END) begin
            cmd_sr <= {cmd_sr[CMD_W-2:0], cmd_in};  // Index then argument, MSB first
        end
        if (busy && bit_cnt > BODY_END && bit_cnt <= CRC_END) begin
            crc_rx <= {crc_rx[CRC_LEN-2:0], cmd_in};
        end
    end

    assign cmd = cmd_sr;

endmodule

//--- rtl/sdio_cmd_resp.sv
`timescale 1ns/10ps

module sdio_cmd_resp import sdio_pkg::*; #(
    parameter int reg_addr_w = 4
) (
    input  logic        clk_sdio,
    input  logic        arst_n,
    input  logic        cmd_valid,
    input  cmd_frame_t  cmd,
    output logic        resp_valid,
    output resp_frame_t resp
);

    localparam int DEPTH  = 1 << reg_addr_w;
    localparam int DATA_W = WR_DATA_HI - WR_DATA_LO + 1;

    logic [DATA_W-1:0]                regs [DEPTH];
    logic [REG_ADDR_HI-REG_ADDR_LO:0] reg_addr;
    logic [reg_addr_w-1:0]            addr;
    logic [DATA_W-1:0]                wr_data;
    logic                             wr;
    logic                             is_rw_direct;
    logic                             is_go_idle;

    assign reg_addr     = cmd.arg[REG_ADDR_HI:REG_ADDR_LO];
    assign addr         = reg_addr[reg_addr_w-1:0];  // Upper address bits alias
    assign wr_data      = cmd.arg[WR_DATA_HI:WR_DATA_LO];
    assign wr           = cmd.arg[RW_FLAG_BIT];
    assign is_rw_direct = cmd_valid && (cmd.index == CMD_IO_RW_DIRECT);
    assign is_go_idle   = cmd_valid && (cmd.index == CMD_GO_IDLE);

    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (is_go_idle) begin
            regs <= '{default: '0};
        end else if (is_rw_direct && wr) begin
            regs[addr] <= wr_data;
        end
    end

    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= is_rw_direct;  // CMD0 and unknown indices stay silent
        end
    end

    // Write echoes the new byte, read returns the stored one
    always_ff @(posedge clk_sdio) begin
        if (is_rw_direct) begin
            resp.index <= cmd.index;
            resp.arg   <= {{(ARG_LEN-DATA_W){1'b0}}, wr ? wr_data : regs[addr]};
        end
    end

endmodule

//--- rtl/sdio_cmd_tx.sv
`timescale 1ns/10ps

module sdio_cmd_tx import sdio_pkg::*; (
    input  logic        clk_sdio,
    input  logic        arst_n,
    input  logic        resp_valid,
    input  resp_frame_t resp,
    output logic        cmd_out,
    output logic        cmd_oe
);

    localparam int SR_W = 1 + $bits(resp_frame_t);  // Transmission bit plus payload

    localparam logic [CNT_W-1:0] CRC_START = CNT_W'(BODY_LEN - 1);
    localparam logic [CNT_W-1:0] END_BIT   = CNT_W'(FRAME_LEN - 1);

    logic               active;
    logic [CNT_W-1:0]   bit_cnt;  // Position currently on the line
    logic [SR_W-1:0]    tx_sr;
    logic [CRC_LEN-1:0] crc;
    logic               crc_en;

    // Each body bit enters the CRC on the edge that drives it
    assign crc_en = active && (bit_cnt < CRC_START);

    sdio_crc7 u_crc (
        .clk_sdio (clk_sdio),
        .arst_n   (arst_n),
        .clear    (!active),
        .enable   (crc_en),
        .data_bit (tx_sr[SR_W-1]),
        .crc      (crc)
    );

    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            active  <= 1'b0;
            bit_cnt <= '0;
            cmd_oe  <= 1'b0;
            cmd_out <= 1'b1;
        end else if (!active) begin
            if (resp_valid) begin
                active  <= 1'b1;
                bit_cnt <= '0;
                cmd_oe  <= 1'b1;
                cmd_out <= 1'b0;  // Start bit
            end
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == END_BIT) begin
                active  <= 1'b0;
                cmd_oe  <= 1'b0;
                cmd_out <= 1'b1;
            end else if (bit_cnt == CRC_START) begin
                cmd_out <= crc[CRC_LEN-1];
            end else begin
                cmd_out <= tx_sr[SR_W-1];
            end
        end
    end

    always_ff @(posedge clk_sdio) begin
        if (!active) begin
            if (resp_valid) begin
                tx_sr <= {1'b0, resp};
            end
        end else if (bit_cnt == CRC_START) begin
            // Rest of the CRC followed by the end bit
            tx_sr <= {crc[CRC_LEN-2:0], 1'b1, {(SR_W-CRC_LEN){1'b0}}};
        end else begin
            tx_sr <= {tx_sr[SR_W-2:0], 1'b0};
        end
    end

endmodule

//--- rtl/sdio_cmd_top.sv
`timescale 1ns/10ps

module sdio_cmd_top import sdio_pkg::*; #(
    parameter int reg_addr_w = 4
) (
    input  logic clk_sdio,
    input  logic arst_n,
    input  logic cmd_in,
    output logic cmd_out,
    output logic cmd_oe,
    output logic crc_error
);

    logic        cmd_valid;
    cmd_frame_t  cmd;
    logic        resp_valid;
    resp_frame_t resp;

    sdio_cmd_rx u_rx (
        .clk_sdio  (clk_sdio),
        .arst_n    (arst_n),
        .cmd_in    (cmd_in),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .crc_error (crc_error)
    );

    sdio_cmd_resp #(
        .reg_addr_w (reg_addr_w)
    ) u_resp (
        .clk_sdio   (clk_sdio),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    sdio_cmd_tx u_tx (
        .clk_sdio   (clk_sdio),
        .arst_n     (arst_n),
        .resp_valid (resp_valid),
        .resp       (resp),
        .cmd_out    (cmd_out),
        .cmd_oe     (cmd_oe)
    );

endmodule

//--- sim/sdio_host_bfm.svh
`ifndef SDIO_HOST_BFM_SVH
`define SDIO_HOST_BFM_SVH

// Bitwise CRC7 over the frame body, x^7 + x^3 + 1, MSB first
function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    int         i;
    c = 7'h00;
    for (i = 39; i >= 0; i--) begin
        fb = bits[i] ^ c[6];
        c  = {c[5:0], 1'b0};
        if (fb) begin
            c = c ^ 7'h09;
        end
    end
    return c;
endfunction

// Returns after the edge that samples the end bit
task automatic send_cmd(input logic [5:0] index, input logic [31:0] arg, input logic bad_crc);
    logic [39:0] body;
    logic [6:0]  crc;
    logic [47:0] frame;
    int          i;
    body = {1'b0, 1'b1, index, arg};
    crc  = crc7_of(body);
    if (bad_crc) begin
        crc[0] = ~crc[0];
    end
    frame = {body, crc, 1'b1};
    for (i = 47; i >= 0; i--) begin
        @(posedge clk_sdio);
        host_bit <= frame[i];
    end
    @(posedge clk_sdio);
endtask

// Watches the line on falling edges, counting crc_error pulses on the way
task automatic wait_for_oe(input int limit, output logic seen, output int cycles,
                           output int errs);
    seen   = 1'b0;
    cycles = 0;
    errs   = 0;
    while (!seen && cycles < limit) begin
        @(negedge clk_sdio);
        cycles++;
        if (crc_error) begin
            errs++;
        end
        if (cmd_oe) begin
            seen = 1'b1;
        end
    end
endtask

task automatic get_resp(output logic [47:0] frame, output int latency, output int oe_len);
    logic seen;
    int   errs;
    int   i;
    wait_for_oe(200, seen, latency, errs);
    if (!seen) begin
        $display("response did not arrive within 200 cycles");
        abort_run();
    end
    frame[47] = cmd_line;  // Start bit
    oe_len    = 1;
    for (i = 46; i >= 0; i--) begin
        @(negedge clk_sdio);
        if (cmd_oe) begin
            oe_len++;
        end
        frame[i] = cmd_line;
    end
    @(negedge clk_sdio);
    if (cmd_oe) begin
        oe_len++;  // Held one cycle too long
    end
endtask

`endif

//--- sim/tb_sdio_cmd.sv
`timescale 1ns/10ps

module tb_sdio_cmd;

    logic       clk_sdio;
    logic       arst_n;
    logic       host_bit;  // Host driver, idles at the pull-up level
    logic       cmd_in;
    logic       cmd_out;
    logic       cmd_oe;
    logic       crc_error;
    logic       cmd_line;
    logic [7:0] model [16];  // Expected register contents

    assign cmd_in   = host_bit;
    assign cmd_line = cmd_oe ? cmd_out : host_bit;

    sdio_cmd_top #(
        .reg_addr_w (4)
    ) dut (
        .clk_sdio  (clk_sdio),
        .arst_n    (arst_n),
        .cmd_in    (cmd_in),
        .cmd_out   (cmd_out),
        .cmd_oe    (cmd_oe),
        .crc_error (crc_error)
    );

    always #20 clk_sdio = ~clk_sdio;

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check(input logic [63:0] expected, input logic [63:0] actual,
                         input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
            abort_run();
        end
    endtask

    `include "sdio_host_bfm.svh"

    function automatic logic [31:0] cmd52_arg(input logic rw, input logic [16:0] addr,
                                              input logic [7:0] data);
        logic [31:0] a;
        a       = 32'h0;
        a[31]   = rw;
        a[25:9] = addr;
        a[7:0]  = data;
        return a;
    endfunction

    // One CMD52 with a full check of the response frame
    task automatic run_cmd52(input logic rw, input logic [16:0] addr, input logic [7:0] data,
                             input logic [7:0] expected);
        logic [47:0] rsp;
        int          latency;
        int          oe_len;
        send_cmd(6'd52, cmd52_arg(rw, addr, data), 1'b0);
        get_resp(rsp, latency, oe_len);
        check(0, rsp[47], "response start bit");
        check(0, rsp[46], "response transmission bit");
        check(52, rsp[45:40], "response index");
        check({24'h0, expected}, rsp[39:8], "response argument");
        check(crc7_of(rsp[47:8]), rsp[7:1], "response CRC7");
        check(1, rsp[0], "response end bit");
        check(3, latency, "cycles from host end bit to cmd_oe");
        check(48, oe_len, "cycles with cmd_oe high");
    endtask

    task automatic write_then_read();
        run_cmd52(1'b1, 17'd5, 8'ha5, 8'ha5);
        model[5] = 8'ha5;
        run_cmd52(1'b0, 17'd5, 8'h00, model[5]);
    endtask

    task automatic corrupted_crc();
        logic seen;
        int   cycles;
        int   errs;
        send_cmd(6'd52, cmd52_arg(1'b1, 17'd5, 8'h3c), 1'b1);
        wait_for_oe(200, seen, cycles, errs);
        check(0, seen, "cmd_oe after a bad CRC");
        check(1, errs, "crc_error pulses");
        run_cmd52(1'b0, 17'd5, 8'h00, model[5]);  // Write must not have landed
    endtask

    task automatic go_idle_clears();
        logic seen;
        int   cycles;
        int   errs;
        run_cmd52(1'b1, 17'd12, 8'h5e, 8'h5e);
        send_cmd(6'd0, 32'h0, 1'b0);
        wait_for_oe(200, seen, cycles, errs);
        check(0, seen, "cmd_oe after CMD0");
        check(0, errs, "crc_error after CMD0");
        model = '{default: 8'h00};
        run_cmd52(1'b0, 17'd5, 8'h00, model[5]);
        run_cmd52(1'b0, 17'd12, 8'h00, model[12]);
    endtask

    task automatic unsupported_index();
        logic seen;
        int   cycles;
        int   errs;
        send_cmd(6'd17, 32'h1234_5678, 1'b0);
        wait_for_oe(200, seen, cycles, errs);
        check(0, seen, "cmd_oe after index 17");
        check(0, errs, "crc_error after index 17");
    endtask

    task automatic random_access();
        logic [16:0] wr_addr;
        logic [16:0] rd_addr;
        logic [7:0]  data;
        int          n;
        for (n = 0; n < 20; n++) begin
            wr_addr = 17'($urandom);
            data    = 8'($urandom);
            run_cmd52(1'b1, wr_addr, data, data);
            model[wr_addr[3:0]] = data;
            if (n % 2 == 0) begin
                rd_addr = {13'($urandom), wr_addr[3:0]};  // Same entry through an alias
            end else begin
                rd_addr = 17'($urandom);
            end
            run_cmd52(1'b0, rd_addr, 8'h00, model[rd_addr[3:0]]);
        end
    endtask

    initial begin
        int seed_val;
        seed_val = $urandom(32'h0010_ab62);
        clk_sdio = 1'b0;
        arst_n   = 1'b0;
        host_bit = 1'b1;
        model    = '{default: 8'h00};
        repeat (10) @(posedge clk_sdio);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk_sdio);
        write_then_read();
        corrupted_crc();
        go_idle_clears();
        unsupported_index();
        random_access();
        $display("test passed");
        $finish;
    end

endmodule

//--- filelist.f
rtl/sdio_pkg.sv
rtl/sdio_crc7.sv
rtl/sdio_cmd_rx.sv
rtl/sdio_cmd_resp.sv
rtl/sdio_cmd_tx.sv
rtl/sdio_cmd_top.sv
+incdir+sim
sim/tb_sdio_cmd.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_sdio_cmd -o tb_sdio_cmd \
    && (./obj_dir/tb_sdio_cmd > sim.log 2>&1 || true) \
    && ! grep -q "test failed" sim.log \
    && grep -q "test passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation FAILED, see sim.log"; exit 1; }
